// ==== include/u2p_cfg.svh ====
`ifndef U2P_CFG_SVH
`define U2P_CFG_SVH

// SPI peripherals: clock chip, DAC, ADC, RX daughterboard
`define U2P_SPI_SLAVES 4

// Largest GMII payload in bytes
`define U2P_MAX_LEN 64

// Idle cycles held after each frame
`define U2P_IFG 12

// Polarity of {ETH_LED, leds[5:1]}
// Ethernet LED is active high, the rest are active low
`define U2P_LED_MASK 6'b011111

`endif

// ==== src/u2p_pkg.sv ====
package u2p_pkg;

   // SPI peripheral select, also the bit index of each enable
   typedef enum logic [1:0]
   {
      SLV_CLK  = 2'd0,
      SLV_DAC  = 2'd1,
      SLV_ADC  = 2'd2,
      SLV_RXDB = 2'd3
   } spi_slave_e;

   typedef enum logic [1:0]
   {
      SPI_IDLE,
      SPI_LOW,     // Clock low, data launched
      SPI_HIGH,    // Clock high, input sampled at end
      SPI_FINISH
   } spi_state_e;

   typedef enum logic [1:0]
   {
      GM_IDLE,
      GM_PREAMBLE,
      GM_PAYLOAD,
      GM_GAP
   } gmii_state_e;

   typedef struct packed
   {
      logic [7:0] txd;
      logic       tx_en;
      logic       tx_er;
   } gmii_tx_t;

   typedef struct packed
   {
      logic sclk;
      logic mosi;
   } spi_bus_t;

   typedef struct packed
   {
      logic [15:0] a;
      logic [15:0] b;
   } dac_pair_t;

   typedef struct packed
   {
      logic [13:0] a;
      logic [13:0] b;
   } adc_pair_t;

endpackage

// ==== src/spi_master.sv ====
`include "u2p_cfg.svh"

module spi_master
(
   input  logic                        GMII_GTX_CLK_int,
   input  logic                        rst_n_i,
   input  logic                        start_i,
   input  u2p_pkg::spi_slave_e         slave_i,
   input  logic [7:0]                  tx_byte_i,
   input  logic                        miso_i,
   output u2p_pkg::spi_bus_t           bus_o,
   output logic [`U2P_SPI_SLAVES-1:0]  sen_n_o,
   output logic                        busy_o,
   output logic                        done_o,
   output logic [7:0]                  rx_byte_o
);

   u2p_pkg::spi_state_e state;
   logic [2:0]          bit_cnt;
   logic [7:0]          shreg;     // Out on the MSB, in on the LSB

   assign busy_o = (state != u2p_pkg::SPI_IDLE);

   always_ff @(posedge GMII_GTX_CLK_int or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state   <= u2p_pkg::SPI_IDLE;
         bit_cnt <= '0;
         bus_o   <= '0;
         sen_n_o <= '1;
         done_o  <= 1'b0;
      end
      else
      begin
         done_o <= 1'b0;
         case (state)
            u2p_pkg::SPI_IDLE:
            begin
               if (start_i)
               begin
                  // One-hot low enable for the chosen peripheral
                  sen_n_o    <= ~({{(`U2P_SPI_SLAVES-1){1'b0}}, 1'b1} << slave_i);
                  bus_o.sclk <= 1'b0;
                  bus_o.mosi <= tx_byte_i[7];
                  bit_cnt    <= '0;
                  state      <= u2p_pkg::SPI_LOW;
               end
            end
            u2p_pkg::SPI_LOW:
            begin
               bus_o.sclk <= 1'b1;
               state      <= u2p_pkg::SPI_HIGH;
            end
            u2p_pkg::SPI_HIGH:
            begin
               bus_o.sclk <= 1'b0;
               if (bit_cnt == 3'd7)
               begin
                  bus_o.mosi <= 1'b0;
                  sen_n_o    <= '1;
                  state      <= u2p_pkg::SPI_FINISH;
               end
               else
               begin
                  bus_o.mosi <= shreg[6];   // Next bit before the shift lands
                  bit_cnt    <= bit_cnt + 3'd1;
                  state      <= u2p_pkg::SPI_LOW;
               end
            end
            default:
            begin
               done_o <= 1'b1;
               state  <= u2p_pkg::SPI_IDLE;
            end
         endcase
      end
   end

   // Data path
   always_ff @(posedge GMII_GTX_CLK_int)
   begin
      if (state == u2p_pkg::SPI_IDLE && start_i)
         shreg <= tx_byte_i;
      else if (state == u2p_pkg::SPI_HIGH)
         shreg <= {shreg[6:0], miso_i};   // Sample at end of high phase
      if (state == u2p_pkg::SPI_FINISH)
         rx_byte_o <= shreg;
   end

endmodule

// ==== src/spi_fanout.sv ====
`include "u2p_cfg.svh"

module spi_fanout
(
   input  u2p_pkg::spi_bus_t           bus_i,
   input  logic [`U2P_SPI_SLAVES-1:0]  sen_n_i,
   input  logic [`U2P_SPI_SLAVES-1:0]  miso_pins_i,
   output logic [`U2P_SPI_SLAVES-1:0]  sclk_pins_o,
   output logic [`U2P_SPI_SLAVES-1:0]  mosi_pins_o,
   output logic                        miso_o
);

   // ADC is write-only, its input line is ignored
   localparam logic [`U2P_SPI_SLAVES-1:0] ret_mask =
      ~({{(`U2P_SPI_SLAVES-1){1'b0}}, 1'b1} << u2p_pkg::SLV_ADC);

   logic [`U2P_SPI_SLAVES-1:0] ret_bits;

   always_comb
   begin
      for (int i = 0; i < `U2P_SPI_SLAVES; i++)
      begin
         // Pins idle low unless this peripheral is enabled
         if (!sen_n_i[i])
         begin
            sclk_pins_o[i] = bus_i.sclk;
            mosi_pins_o[i] = bus_i.mosi;
         end
         else
         begin
            sclk_pins_o[i] = 1'b0;
            mosi_pins_o[i] = 1'b0;
         end
         ret_bits[i] = ~sen_n_i[i] & miso_pins_i[i] & ret_mask[i];
      end
   end

   assign miso_o = |ret_bits;   // Wired-OR of enabled return lines

endmodule

// ==== src/gmii_tx_framer.sv ====
`include "u2p_cfg.svh"

module gmii_tx_framer
(
   input  logic                                GMII_GTX_CLK_int,
   input  logic                                rst_n_i,
   input  logic                                send_i,
   input  logic [$clog2(`U2P_MAX_LEN+1)-1:0]   len_i,
   input  logic [7:0]                          seed_i,
   input  logic                                abort_i,
   output u2p_pkg::gmii_tx_t                   gmii_o,
   output logic                                busy_o
);

   localparam int len_w = $clog2(`U2P_MAX_LEN + 1);

   u2p_pkg::gmii_state_e state;
   logic [len_w-1:0]     cnt;       // Preamble, payload or gap count
   logic [len_w-1:0]     len_q;
   logic [7:0]           seed_q;
   logic                 accept;

   assign busy_o = (state != u2p_pkg::GM_IDLE);
   assign accept = send_i && (state == u2p_pkg::GM_IDLE);

   always_ff @(posedge GMII_GTX_CLK_int)
   begin
      if (accept)
      begin
         len_q  <= len_i;
         seed_q <= seed_i;
      end
   end

   always_ff @(posedge GMII_GTX_CLK_int or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state  <= u2p_pkg::GM_IDLE;
         cnt    <= '0;
         gmii_o <= '0;
      end
      else
      begin
         case (state)
            u2p_pkg::GM_IDLE:
            begin
               if (accept)
               begin
                  gmii_o <= '{txd: 8'h55, tx_en: 1'b1, tx_er: 1'b0};
                  cnt    <= len_w'(1);
                  state  <= u2p_pkg::GM_PREAMBLE;
               end
            end
            u2p_pkg::GM_PREAMBLE:
            begin
               gmii_o.tx_er <= abort_i;
               if (cnt == len_w'(7))
               begin
                  gmii_o.txd <= 8'hD5;   // Start delimiter
                  cnt        <= '0;
                  state      <= u2p_pkg::GM_PAYLOAD;
               end
               else
               begin
                  gmii_o.txd <= 8'h55;
                  cnt        <= cnt + len_w'(1);
               end
               if (abort_i)
               begin
                  cnt   <= '0;
                  state <= u2p_pkg::GM_GAP;
               end
            end
            u2p_pkg::GM_PAYLOAD:
            begin
               gmii_o.txd   <= seed_q + 8'(cnt);
               gmii_o.tx_er <= abort_i;
               if (abort_i || cnt == len_q - len_w'(1))
               begin
                  cnt   <= '0;
                  state <= u2p_pkg::GM_GAP;
               end
               else
                  cnt <= cnt + len_w'(1);
            end
            default:
            begin
               gmii_o <= '0;   // Line idle, still busy
               if (cnt == len_w'(`U2P_IFG))
                  state <= u2p_pkg::GM_IDLE;
               else
                  cnt <= cnt + len_w'(1);
            end
         endcase
      end
   end

endmodule

// ==== src/pin_map.sv ====
`include "u2p_cfg.svh"

module pin_map
(
   input  logic                 GMII_GTX_CLK_int,
   input  logic                 rst_n_i,
   input  u2p_pkg::adc_pair_t   adc_raw_i,
   input  u2p_pkg::dac_pair_t   dac_core_i,
   input  logic [5:0]           leds_core_i,
   output u2p_pkg::adc_pair_t   adc_o,
   output u2p_pkg::dac_pair_t   dac_pins_o,
   output logic [5:0]           leds_n_o
);

   // Board routing corrections
   always_ff @(posedge GMII_GTX_CLK_int)
   begin
      adc_o.a <= ~adc_raw_i.a;   // ADC A routed inverted
      adc_o.b <= adc_raw_i.b;

      // DAC channels swapped on the board, A also inverted
      dac_pins_o.a <= ~dac_core_i.b;
      dac_pins_o.b <= dac_core_i.a;
   end

   // All LEDs off out of reset
   always_ff @(posedge GMII_GTX_CLK_int or negedge rst_n_i)
   begin
      if (!rst_n_i)
         leds_n_o <= `U2P_LED_MASK;
      else
         leds_n_o <= leds_core_i ^ `U2P_LED_MASK;
   end

endmodule

// ==== src/u2p_top.sv ====
`include "u2p_cfg.svh"

module u2p_top
(
   input  logic                                GMII_GTX_CLK_int,
   input  logic                                rst_n_i,
   // SPI control
   input  logic                                spi_start_i,
   input  u2p_pkg::spi_slave_e                 spi_slave_i,
   input  logic [7:0]                          spi_tx_byte_i,
   output logic                                spi_busy_o,
   output logic                                spi_done_o,
   output logic [7:0]                          spi_rx_byte_o,
   // SPI pins, one bit per peripheral
   output logic [`U2P_SPI_SLAVES-1:0]          spi_sen_n_o,
   output logic [`U2P_SPI_SLAVES-1:0]          spi_sclk_o,
   output logic [`U2P_SPI_SLAVES-1:0]          spi_mosi_o,
   input  logic [`U2P_SPI_SLAVES-1:0]          spi_miso_i,
   // GMII transmit
   input  logic                                gmii_send_i,
   input  logic [$clog2(`U2P_MAX_LEN+1)-1:0]   gmii_len_i,
   input  logic [7:0]                          gmii_seed_i,
   input  logic                                gmii_abort_i,
   output u2p_pkg::gmii_tx_t                   gmii_o,
   output logic                                gmii_busy_o,
   // Converters and LEDs
   input  u2p_pkg::adc_pair_t                  adc_raw_i,
   input  u2p_pkg::dac_pair_t                  dac_core_i,
   input  logic [5:0]                          leds_core_i,
   output u2p_pkg::adc_pair_t                  adc_o,
   output u2p_pkg::dac_pair_t                  dac_pins_o,
   output logic [5:0]                          leds_n_o
);

   u2p_pkg::spi_bus_t spi_bus;
   logic              spi_miso;   // Merged return data

   spi_master u_spi_master
   (
      .GMII_GTX_CLK_int (GMII_GTX_CLK_int),
      .rst_n_i          (rst_n_i),
      .start_i          (spi_start_i),
      .slave_i          (spi_slave_i),
      .tx_byte_i        (spi_tx_byte_i),
      .miso_i           (spi_miso),
      .bus_o            (spi_bus),
      .sen_n_o          (spi_sen_n_o),
      .busy_o           (spi_busy_o),
      .done_o           (spi_done_o),
      .rx_byte_o        (spi_rx_byte_o)
   );

   spi_fanout u_spi_fanout
   (
      .bus_i       (spi_bus),
      .sen_n_i     (spi_sen_n_o),
      .miso_pins_i (spi_miso_i),
      .sclk_pins_o (spi_sclk_o),
      .mosi_pins_o (spi_mosi_o),
      .miso_o      (spi_miso)
   );

   gmii_tx_framer u_gmii_tx_framer
   (
      .GMII_GTX_CLK_int (GMII_GTX_CLK_int),
      .rst_n_i          (rst_n_i),
      .send_i           (gmii_send_i),
      .len_i            (gmii_len_i),
      .seed_i           (gmii_seed_i),
      .abort_i          (gmii_abort_i),
      .gmii_o           (gmii_o),
      .busy_o           (gmii_busy_o)
   );

   pin_map u_pin_map
   (
      .GMII_GTX_CLK_int (GMII_GTX_CLK_int),
      .rst_n_i          (rst_n_i),
      .adc_raw_i        (adc_raw_i),
      .dac_core_i       (dac_core_i),
      .leds_core_i      (leds_core_i),
      .adc_o            (adc_o),
      .dac_pins_o       (dac_pins_o),
      .leds_n_o         (leds_n_o)
   );

endmodule

// ==== bench/clk_gen.sv ====
module clk_gen
(
   output logic clk_o,
   output logic rst_n_o
);

   localparam int half_period = 20;

   initial
   begin
      clk_o   = 1'b0;
      rst_n_o = 1'b0;
      repeat (4) @(posedge clk_o);
      rst_n_o <= 1'b1;   // Released after four rising edges
   end

   always #half_period clk_o = ~clk_o;

endmodule

// ==== bench/tb_u2p_top.sv ====
`include "u2p_cfg.svh"

module tb_u2p_top;

   localparam int clk_period = 40;
   localparam int n_spi      = 40;
   localparam int n_frames   = 20;
   localparam int n_pins     = 50;
   localparam int len_w      = $clog2(`U2P_MAX_LEN + 1);
   // Longest transfer and frame doubled plus margin
   localparam int run_cycles =
      2 * (n_spi * 22 + n_frames * (`U2P_MAX_LEN + `U2P_IFG + 16) + n_pins + 20) + 200;

   logic                         GMII_GTX_CLK_int;
   logic                         rst_n;
   logic                         spi_start;
   u2p_pkg::spi_slave_e          spi_slave;
   logic [7:0]                   spi_tx_byte;
   logic                         spi_busy;
   logic                         spi_done;
   logic [7:0]                   spi_rx_byte;
   logic [`U2P_SPI_SLAVES-1:0]   spi_sen_n;
   logic [`U2P_SPI_SLAVES-1:0]   spi_sclk;
   logic [`U2P_SPI_SLAVES-1:0]   spi_mosi;
   logic [`U2P_SPI_SLAVES-1:0]   spi_miso;
   logic                         gmii_send;
   logic [len_w-1:0]             gmii_len;
   logic [7:0]                   gmii_seed;
   logic                         gmii_abort;
   u2p_pkg::gmii_tx_t            gmii;
   logic                         gmii_busy;
   u2p_pkg::adc_pair_t           adc_raw;
   u2p_pkg::dac_pair_t           dac_core;
   logic [5:0]                   leds_core;
   u2p_pkg::adc_pair_t           adc;
   u2p_pkg::dac_pair_t           dac_pins;
   logic [5:0]                   leds_n;
   logic [7:0]                   slave_byte [`U2P_SPI_SLAVES];   // Byte each peripheral returns
   logic [7:0]                   slave_sh [`U2P_SPI_SLAVES];
   int                           error_count = 0;
   int                           check_count = 0;

   clk_gen u_clk_gen (.clk_o(GMII_GTX_CLK_int), .rst_n_o(rst_n));

   u2p_top DUT
   (
      .GMII_GTX_CLK_int (GMII_GTX_CLK_int), .rst_n_i       (rst_n),
      .spi_start_i      (spi_start),        .spi_slave_i   (spi_slave),
      .spi_tx_byte_i    (spi_tx_byte),      .spi_busy_o    (spi_busy),
      .spi_done_o       (spi_done),         .spi_rx_byte_o (spi_rx_byte),
      .spi_sen_n_o      (spi_sen_n),        .spi_sclk_o    (spi_sclk),
      .spi_mosi_o       (spi_mosi),         .spi_miso_i    (spi_miso),
      .gmii_send_i      (gmii_send),        .gmii_len_i    (gmii_len),
      .gmii_seed_i      (gmii_seed),        .gmii_abort_i  (gmii_abort),
      .gmii_o           (gmii),             .gmii_busy_o   (gmii_busy),
      .adc_raw_i        (adc_raw),          .dac_core_i    (dac_core),
      .leds_core_i      (leds_core),        .adc_o         (adc),
      .dac_pins_o       (dac_pins),         .leds_n_o      (leds_n)
   );

   // Peripheral models shift MSB first on each falling clock pin
   always @(posedge GMII_GTX_CLK_int)
   begin
      for (int i = 0; i < `U2P_SPI_SLAVES; i++)
      begin
         if (spi_sen_n[i])
         begin
            slave_sh[i] <= slave_byte[i];
            spi_miso[i] <= slave_byte[i][7];
         end
         else if (spi_sclk[i])   // Clock pin falls at this edge
         begin
            slave_sh[i] <= {slave_sh[i][6:0], 1'b0};
            spi_miso[i] <= slave_sh[i][6];
         end
      end
   end

   task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
      check_count++;
      if (got !== exp)
      begin
         error_count++;
         $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_gmii(input string what, input u2p_pkg::gmii_tx_t got,
                             input u2p_pkg::gmii_tx_t exp);
      check_count++;
      if (got !== exp)
      begin
         error_count++;
         $display("[FAIL] %0t: %s got txd %h en %b er %b expected txd %h en %b er %b", $time,
                  what, got.txd, got.tx_en, got.tx_er, exp.txd, exp.tx_en, exp.tx_er);
      end
   endtask

   task automatic check_dac(input string what, input u2p_pkg::dac_pair_t got,
                            input u2p_pkg::dac_pair_t exp);
      check_count++;
      if (got !== exp)
      begin
         error_count++;
         $display("[FAIL] %0t: %s got %h/%h expected %h/%h", $time, what, got.a, got.b,
                  exp.a, exp.b);
      end
   endtask

   task automatic check_adc(input string what, input u2p_pkg::adc_pair_t got,
                            input u2p_pkg::adc_pair_t exp);
      check_count++;
      if (got !== exp)
      begin
         error_count++;
         $display("[FAIL] %0t: %s got %h/%h expected %h/%h", $time, what, got.a, got.b,
                  exp.a, exp.b);
      end
   endtask

   task automatic spi_transfer(input u2p_pkg::spi_slave_e sel, input logic [7:0] tx);
      logic [7:0] peer [`U2P_SPI_SLAVES];
      logic [7:0] mosi_bits = '0;
      int         nbits = 0;
      int         cycles = 0;
      for (int i = 0; i < `U2P_SPI_SLAVES; i++)
         peer[i] = 8'($urandom);
      @(posedge GMII_GTX_CLK_int);
      for (int i = 0; i < `U2P_SPI_SLAVES; i++)
         slave_byte[i] <= peer[i];
      spi_start   <= 1'b1;
      spi_slave   <= sel;
      spi_tx_byte <= tx;
      @(negedge GMII_GTX_CLK_int);   // Cycle 0 with start visible
      @(posedge GMII_GTX_CLK_int);
      spi_start <= 1'b0;
      while (!spi_done && cycles < 30)
      begin
         @(negedge GMII_GTX_CLK_int);
         cycles++;
         for (int i = 0; i < `U2P_SPI_SLAVES; i++)
            if (i != int'(sel))
               check_byte("unselected enable/clock/data", {5'b0, spi_sen_n[i], spi_sclk[i],
                          spi_mosi[i]}, 8'h04);
         if (!spi_done)
            check_byte("SPI busy during transfer", 8'(spi_busy), 8'h01);
         if (spi_sclk[sel])
         begin
            mosi_bits = {mosi_bits[6:0], spi_mosi[sel]};
            nbits++;
         end
      end
      if (!spi_done)
      begin
         error_count++;
         $display("SPI transfer to peripheral %0d never raised done", sel);
      end
      else
      begin
         check_byte("SPI start to done cycles", 8'(cycles), 8'd18);
         check_byte("SPI clock high phases", 8'(nbits), 8'd8);
         check_byte("SPI bits on data pin", mosi_bits, tx);
         check_byte("SPI received byte", spi_rx_byte,
                    (sel == u2p_pkg::SLV_ADC) ? 8'h00 : peer[sel]);   // ADC returns nothing
      end
   endtask

   task automatic send_frame(input logic [len_w-1:0] len, input logic [7:0] seed,
                             input bit abort_en, input int abort_at);
      u2p_pkg::gmii_tx_t exp;
      int                last;
      int                nbytes = 0;
      int                gap = 0;
      int                cyc = 0;
      last = abort_en ? abort_at : 7 + int'(len);
      @(posedge GMII_GTX_CLK_int);
      gmii_send <= 1'b1;
      gmii_len  <= len;
      gmii_seed <= seed;
      do
      begin
         @(posedge GMII_GTX_CLK_int);
         cyc++;
         gmii_send  <= (cyc <= 7) && ($urandom % 2 == 1);   // Requests while busy
         gmii_len   <= len_w'(1 + $urandom % `U2P_MAX_LEN);
         gmii_seed  <= 8'($urandom);
         gmii_abort <= abort_en && (cyc == abort_at);
         @(negedge GMII_GTX_CLK_int);
         if (gmii.tx_en)
         begin
            exp.txd   = (nbytes < 7) ? 8'h55 : (nbytes == 7) ? 8'hD5 : seed + 8'(nbytes - 8);
            exp.tx_en = 1'b1;
            exp.tx_er = abort_en && (nbytes == abort_at);
            check_gmii("frame byte", gmii, exp);
            nbytes++;
         end
         else if (nbytes == 0)
         begin
            error_count++;
            $display("Frame did not start one cycle after the send pulse");
         end
         else if (gmii_busy)
         begin
            check_gmii("gap line state", gmii, '0);
            gap++;
         end
      end
      while ((gmii.tx_en || gmii_busy) && nbytes > 0 && cyc < 150);
      if (cyc >= 150)
      begin
         error_count++;
         $display("Framer stayed busy far beyond the longest frame");
      end
      check_byte("transmit enable cycles", 8'(nbytes), 8'(last + 1));
      check_byte("inter-frame gap cycles", 8'(gap), 8'(`U2P_IFG));
   endtask

   task automatic drive_pins(input int count);
      u2p_pkg::adc_pair_t adc_in;
      u2p_pkg::dac_pair_t dac_in;
      u2p_pkg::adc_pair_t adc_exp;
      u2p_pkg::dac_pair_t dac_exp;
      logic [5:0]         led_in;
      for (int n = 0; n < count; n++)
      begin
         @(posedge GMII_GTX_CLK_int);
         adc_raw   <= 28'($urandom);
         dac_core  <= {16'($urandom), 16'($urandom)};
         leds_core <= 6'($urandom);
         @(negedge GMII_GTX_CLK_int);
         if (n > 0)   // Outputs now show the previous inputs
         begin
            adc_exp.a = ~adc_in.a;
            adc_exp.b = adc_in.b;
            dac_exp.a = ~dac_in.b;
            dac_exp.b = dac_in.a;
            check_adc("ADC words", adc, adc_exp);
            check_dac("DAC pins", dac_pins, dac_exp);
            check_byte("LED pins", 8'(leds_n), 8'(led_in ^ `U2P_LED_MASK));
         end
         adc_in = adc_raw;
         dac_in = dac_core;
         led_in = leds_core;
      end
   endtask

   initial
   begin
      #(run_cycles * clk_period);
      $display("Watchdog expired after %0d cycles, tests did not finish", run_cycles);
      $display("checks %0d, errors %0d", check_count, error_count);
      $display("=== FAIL ===");
      $finish;
   end

   initial
   begin
      logic [len_w-1:0] len;
      bit               do_abort;
      void'($urandom(21));
      spi_start   = 1'b0;
      spi_slave   = u2p_pkg::SLV_CLK;
      spi_tx_byte = '0;
      spi_miso    = '0;
      gmii_send   = 1'b0;
      gmii_len    = '0;
      gmii_seed   = '0;
      gmii_abort  = 1'b0;
      adc_raw     = '0;
      dac_core    = '0;
      leds_core   = '0;
      for (int i = 0; i < `U2P_SPI_SLAVES; i++)
         slave_byte[i] = '0;
      @(posedge rst_n);
      @(negedge GMII_GTX_CLK_int);
      check_byte("enables after reset", 8'(spi_sen_n), 8'({`U2P_SPI_SLAVES{1'b1}}));
      check_byte("SPI clock pins after reset", 8'(spi_sclk), 8'h00);
      check_byte("SPI data pins after reset", 8'(spi_mosi), 8'h00);
      check_byte("busy and done after reset", {5'b0, spi_busy, spi_done, gmii_busy}, 8'h00);
      check_gmii("GMII after reset", gmii, '0);
      check_byte("LED pins after reset", 8'(leds_n), 8'(`U2P_LED_MASK));
      repeat (n_spi)
         spi_transfer(u2p_pkg::spi_slave_e'(2'($urandom % 4)), 8'($urandom));
      for (int f = 0; f < n_frames; f++)
      begin
         len      = len_w'(1 + $urandom % `U2P_MAX_LEN);
         do_abort = ($urandom % 3 == 0);
         send_frame(len, 8'($urandom), do_abort, 1 + int'($urandom % (7 + int'(len))));
      end
      drive_pins(n_pins + 1);
      $display("checks %0d, errors %0d", check_count, error_count);
      if (error_count == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

// ==== files.f ====
+incdir+include
src/u2p_pkg.sv
src/spi_master.sv
src/spi_fanout.sv
src/gmii_tx_framer.sv
src/pin_map.sv
src/u2p_top.sv
bench/clk_gen.sv
bench/tb_u2p_top.sv

// ==== Bender.yml ====
package:
  name: u2p_top

export_include_dirs:
  - include

sources:
  - files:
      - src/u2p_pkg.sv
      - src/spi_master.sv
      - src/spi_fanout.sv
      - src/gmii_tx_framer.sv
      - src/pin_map.sv
      - src/u2p_top.sv
  - target: test
    files:
      - bench/clk_gen.sv
      - bench/tb_u2p_top.sv
